//--- Makefile
TOP = accumulatorMachineTb

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f accumulatorMachine.f -o simv
	out=$$(./obj_dir/simv 2>&1); echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f accumulatorMachine.f

clean:
	rm -rf obj_dir

//--- accumulatorMachine.f
logic/memPkg.sv
logic/isaPkg.sv
logic/alu.sv
logic/mainMemory.sv
logic/controlUnit.sv
logic/hostPort.sv
logic/accumulatorMachine.sv
testbench/accumulatorMachineTb.sv

//--- logic/accumulatorMachine.sv
`timescale 1ns/100ps
`default_nettype none

module accumulatorMachine
    import memPkg::*;
(
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 hostReq,
    input  logic                 hostWrite,
    input  logic [addrWidth-1:0] hostAddr,
    input  logic [wordWidth-1:0] hostWriteData,
    output logic                 halted,
    output logic [wordWidth-1:0] accumulator,
    output logic                 hostAck,
    output logic [wordWidth-1:0] hostReadData
);

    // processor side of the memory mux
    logic [addrWidth-1:0] cpuAddr;
    logic [wordWidth-1:0] cpuWriteData;
    logic                 cpuWrite;

    // shared memory port
    logic [addrWidth-1:0] memAddr;
    logic [wordWidth-1:0] memWriteData;
    logic                 memWrite;
    logic [wordWidth-1:0] memReadData;

    controlUnit controlUnit_i (
        .clock(clock),
        .rst(rst),
        .start(start),
        .memReadData(memReadData),
        .memAddr(cpuAddr),
        .memWriteData(cpuWriteData),
        .memWrite(cpuWrite),
        .halted(halted),
        .accumulator(accumulator)
    );

    hostPort hostPort_i (
        .clock(clock),
        .rst(rst),
        .hostReq(hostReq),
        .hostWrite(hostWrite),
        .hostAddr(hostAddr),
        .hostWriteData(hostWriteData),
        .halted(halted),
        .cpuAddr(cpuAddr),
        .cpuWriteData(cpuWriteData),
        .cpuWrite(cpuWrite),
        .memReadData(memReadData),
        .hostAck(hostAck),
        .hostReadData(hostReadData),
        .memAddr(memAddr),
        .memWriteData(memWriteData),
        .memWrite(memWrite)
    );

    mainMemory mainMemory_i (
        .clock(clock),
        .address(memAddr),
        .writeData(memWriteData),
        .write(memWrite),
        .readData(memReadData)
    );

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
    import isaPkg::*, memPkg::*;
(
    input  aluOp                 op,
    input  logic [wordWidth-1:0] operand1,
    input  logic [wordWidth-1:0] operand2,
    output logic [wordWidth-1:0] result
);

    always_comb begin
        case (op)
            aluAdd: result = operand1 + operand2;
            aluSub: result = operand1 - operand2;
            // low half of the product only
            aluMul: result = operand1 * operand2;
            aluDiv: begin
                // divide by zero saturates to all ones
                if (operand2 == '0) begin
                    result = '1;
                end else begin
                    result = operand1 / operand2;
                end
            end
            // shifts and rotates by one, operand2 ignored
            aluShl: result = operand1 << 1;
            aluShr: result = operand1 >> 1;
            aluRol: result = {operand1[wordWidth-2:0], operand1[wordWidth-1]};
            aluRor: result = {operand1[0], operand1[wordWidth-1:1]};
            aluAnd: result = operand1 & operand2;
            aluOr: result = operand1 | operand2;
            aluXor: result = operand1 ^ operand2;
            aluNor: result = ~(operand1 | operand2);
            aluNand: result = ~(operand1 & operand2);
            aluXnor: result = ~(operand1 ^ operand2);
            // compares give 1 or 0, unsigned
            aluGreater: result = {{(wordWidth-1){1'b0}}, operand1 > operand2};
            aluEqual: result = {{(wordWidth-1){1'b0}}, operand1 == operand2};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit
    import isaPkg::*, memPkg::*;
(
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 start,
    input  logic [wordWidth-1:0] memReadData,
    output logic [addrWidth-1:0] memAddr,
    output logic [wordWidth-1:0] memWriteData,
    output logic                 memWrite,
    output logic                 halted,
    output logic [wordWidth-1:0] accumulator
);

    typedef enum logic [2:0] {
        idle,
        fetch,
        fetchWait,
        operandWait,
        execute
    } cuState;

    cuState state;

    // processor registers
    logic [addrWidth-1:0] pc;
    instruction ir;
    logic [addrWidth-1:0] mar;
    logic [wordWidth-1:0] mbr;
    logic [wordWidth-1:0] b;

    // memory word seen as an instruction during fetchWait
    instruction fetched;

    logic [wordWidth-1:0] aluOperand2;
    logic [wordWidth-1:0] aluResult;

    assign fetched = memReadData;

    // immediate is zero-extended
    assign aluOperand2 = (ir.alu.op == opAluImm)
        ? {{(wordWidth-immWidth){1'b0}}, ir.alu.immediate} : b;

    alu alu_i (
        .op(ir.alu.func),
        .operand1(accumulator),
        .operand2(aluOperand2),
        .result(aluResult)
    );

    // mar addresses every fetch and operand access
    assign memAddr = mar;
    assign memWriteData = mbr;
    assign memWrite = (state == execute) && (ir.mem.op == opStore);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= idle;
            halted <= 1'b1;
            pc <= '0;
            b <= '0;
            accumulator <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        pc <= '0;
                        mar <= '0;
                        halted <= 1'b0;
                        state <= fetch;
                    end
                end
                // instruction address issued from mar
                fetch: begin
                    state <= fetchWait;
                end
                fetchWait: begin
                    ir <= fetched;
                    // pc wraps at memDepth with the address width
                    pc <= pc + 1'b1;
                    mar <= fetched.mem.address;
                    // store data staged here
                    mbr <= accumulator;
                    // B is read through the same wait so alu timing is uniform
                    if (fetched.mem.op inside {opLoad, opLoadB, opAlu}) begin
                        state <= operandWait;
                    end else begin
                        state <= execute;
                    end
                end
                // operand read in flight
                operandWait: begin
                    state <= execute;
                end
                execute: begin
                    state <= fetch;
                    mar <= pc;
                    case (ir.mem.op)
                        opLoad: accumulator <= memReadData;
                        opStore: begin
                            // write driven combinationally this cycle
                        end
                        opLoadB: b <= memReadData;
                        opAlu, opAluImm: accumulator <= aluResult;
                        opJump: begin
                            pc <= ir.mem.address;
                            mar <= ir.mem.address;
                        end
                        opJumpZero: begin
                            if (accumulator == '0) begin
                                pc <= ir.mem.address;
                                mar <= ir.mem.address;
                            end
                        end
                        // opHalt and unused codes
                        default: begin
                            halted <= 1'b1;
                            state <= idle;
                        end
                    endcase
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/hostPort.sv
`timescale 1ns/100ps
`default_nettype none

module hostPort
    import memPkg::*;
(
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 hostReq,
    input  logic                 hostWrite,
    input  logic [addrWidth-1:0] hostAddr,
    input  logic [wordWidth-1:0] hostWriteData,
    input  logic                 halted,
    input  logic [addrWidth-1:0] cpuAddr,
    input  logic [wordWidth-1:0] cpuWriteData,
    input  logic                 cpuWrite,
    input  logic [wordWidth-1:0] memReadData,
    output logic                 hostAck,
    output logic [wordWidth-1:0] hostReadData,
    output logic [addrWidth-1:0] memAddr,
    output logic [wordWidth-1:0] memWriteData,
    output logic                 memWrite
);

    typedef enum logic [1:0] {
        idle,
        access,
        capture,
        ackHigh
    } hpState;

    hpState state;
    logic hostGrant;

    // host owns memory only while its access is in flight
    assign hostGrant = (state == access) || (state == capture);

    assign memAddr = hostGrant ? hostAddr : cpuAddr;
    assign memWriteData = hostGrant ? hostWriteData : cpuWriteData;
    // single write, in the access cycle only
    assign memWrite = hostGrant ? (hostWrite && state == access) : cpuWrite;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= idle;
            hostAck <= 1'b0;
        end else begin
            case (state)
                // request held off while the program runs
                idle: if (hostReq && halted) state <= access;
                access: state <= capture;
                capture: begin
                    // registered read data is valid now
                    hostReadData <= memReadData;
                    hostAck <= 1'b1;
                    state <= ackHigh;
                end
                ackHigh: begin
                    if (!hostReq) begin
                        hostAck <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/isaPkg.sv
`default_nettype none

package isaPkg;

    import memPkg::*;

    localparam int opcodeWidth = 4;
    localparam int immWidth = 8;

    // codes 8 to 15 are unused and run as halt
    typedef enum logic [opcodeWidth-1:0] {
        opHalt     = 4'd0,
        opLoad     = 4'd1,
        opStore    = 4'd2,
        opLoadB    = 4'd3,
        opAlu      = 4'd4,
        opAluImm   = 4'd5,
        opJump     = 4'd6,
        opJumpZero = 4'd7
    } opcode;

    // sixteen operations in codes 0 to 15
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluMul, aluDiv,
        aluShl, aluShr, aluRol, aluRor,
        aluAnd, aluOr, aluXor, aluNor,
        aluNand, aluXnor, aluGreater, aluEqual
    } aluOp;

    // load, store and jump view
    typedef struct packed {
        opcode op;
        logic [addrWidth-1:0] address;
    } memFormat;

    // alu view with an immediate for opAluImm
    typedef struct packed {
        opcode op;
        aluOp func;
        logic [immWidth-1:0] immediate;
    } aluFormat;

    // one instruction word decoded both ways
    typedef union packed {
        memFormat mem;
        aluFormat alu;
    } instruction;

endpackage

`default_nettype wire

//--- logic/mainMemory.sv
`timescale 1ns/100ps
`default_nettype none

module mainMemory
    import memPkg::*;
(
    input  logic                 clock,
    input  logic [addrWidth-1:0] address,
    input  logic [wordWidth-1:0] writeData,
    input  logic                 write,
    output logic [wordWidth-1:0] readData
);

    // word storage
    logic [wordWidth-1:0] memory [memDepth];

    always_ff @(posedge clock) begin
        if (write) begin
            memory[address] <= writeData;
        end
        // read every cycle, old word on a write
        readData <= memory[address];
    end

endmodule

`default_nettype wire

//--- logic/memPkg.sv
`default_nettype none

package memPkg;

    // data and instruction width
    localparam int wordWidth = 16;

    // word address width
    localparam int addrWidth = 12;

    // one word per address, full address space
    localparam int memDepth = 4096;

endpackage

`default_nettype wire

//--- testbench/accumulatorMachineTb.sv
`timescale 1ns/100ps
`default_nettype none

module accumulatorMachineTb
    import isaPkg::*, memPkg::*;
();

    localparam int testCount = 5;
    localparam int waitLimit = 2000;
    localparam logic [addrWidth-1:0] dataA = 12'h100;
    localparam logic [addrWidth-1:0] dataB = 12'h101;
    localparam logic [addrWidth-1:0] dataOut = 12'h102;

    logic clock;
    logic rst;
    logic start;
    logic hostReq;
    logic hostWrite;
    logic [addrWidth-1:0] hostAddr;
    logic [wordWidth-1:0] hostWriteData;
    logic halted;
    logic [wordWidth-1:0] accumulator;
    logic hostAck;
    logic [wordWidth-1:0] hostReadData;

    logic [31:0] lfsrState = 32'hbac8;
    int reqLowCycles = 0;

    accumulatorMachine accumulatorMachine_i (
        .clock(clock), .rst(rst), .start(start),
        .hostReq(hostReq), .hostWrite(hostWrite), .hostAddr(hostAddr),
        .hostWriteData(hostWriteData), .halted(halted), .accumulator(accumulator),
        .hostAck(hostAck), .hostReadData(hostReadData)
    );

    always #20 clock = ~clock;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [wordWidth-1:0] actual,
            input logic [wordWidth-1:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED at %0t: %s is 0x%h, expected 0x%h",
                $time, name, actual, expected));
        end
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // expected alu result from 32-bit copies of the operands
    function automatic logic [wordWidth-1:0] aluModel(input aluOp op,
            input logic [wordWidth-1:0] a, input logic [wordWidth-1:0] b);
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] wide;
        x = {16'h0000, a};
        y = {16'h0000, b};
        case (op)
            aluAdd: wide = x + y;
            aluSub: wide = x - y;
            aluMul: wide = x * y;
            aluDiv: wide = (y == 32'd0) ? 32'hffff : x / y;
            aluShl: wide = x * 2;
            aluShr: wide = x / 2;
            // window into the doubled word picks the rotation
            aluRol: wide = {a, a} >> 15;
            aluRor: wide = {a, a} >> 1;
            aluAnd: wide = x & y;
            aluOr: wide = x | y;
            aluXor: wide = x ^ y;
            aluNor: wide = ~(x | y);
            aluNand: wide = ~(x & y);
            aluXnor: wide = ~(x ^ y);
            aluGreater: wide = (x > y) ? 32'd1 : 32'd0;
            aluEqual: wide = (x == y) ? 32'd1 : 32'd0;
            default: wide = '0;
        endcase
        return wide[wordWidth-1:0];
    endfunction

    // assembler building both formats through the union
    function automatic logic [wordWidth-1:0] encodeMem(input opcode op,
            input logic [addrWidth-1:0] address);
        instruction word;
        word.mem.op = op;
        word.mem.address = address;
        return word;
    endfunction

    function automatic logic [wordWidth-1:0] encodeAlu(input opcode op, input aluOp func,
            input logic [immWidth-1:0] imm);
        instruction word;
        word.alu.op = op;
        word.alu.func = func;
        word.alu.immediate = imm;
        return word;
    endfunction

    task automatic waitForAck(input logic level);
        int cycles;
        cycles = 0;
        while (hostAck !== level) begin
            @(negedge clock);
            cycles++;
            if (cycles > waitLimit) begin
                abortRun("host port handshake did not complete in time");
            end
        end
    endtask

    // one four-phase transaction
    task automatic hostTransfer(input logic write, input logic [addrWidth-1:0] address,
            input logic [wordWidth-1:0] data, output logic [wordWidth-1:0] readData);
        @(negedge clock);
        hostWrite = write;
        hostAddr = address;
        hostWriteData = data;
        hostReq = 1'b1;
        waitForAck(1'b1);
        readData = hostReadData;
        hostReq = 1'b0;
        waitForAck(1'b0);
    endtask

    task automatic hostWriteWord(input logic [addrWidth-1:0] address,
            input logic [wordWidth-1:0] data);
        logic [wordWidth-1:0] unused;
        hostTransfer(1'b1, address, data, unused);
    endtask

    task automatic hostReadWord(input logic [addrWidth-1:0] address,
            output logic [wordWidth-1:0] data);
        hostTransfer(1'b0, address, '0, data);
    endtask

    task automatic pulseStart();
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        checkValue("halted after start", 16'(halted), 16'd0);
    endtask

    task automatic runProgram();
        int cycles;
        cycles = 0;
        pulseStart();
        while (!halted) begin
            @(negedge clock);
            cycles++;
            if (cycles > waitLimit) begin
                abortRun("program did not halt in time");
            end
        end
    endtask

    // low nibble of each address is its index
    task automatic hostRoundTrip();
        logic [addrWidth-1:0] addrs [8];
        logic [wordWidth-1:0] words [8];
        logic [31:0] r;
        logic [wordWidth-1:0] got;
        for (int i = 0; i < 8; i++) begin
            r = randomBits(8);
            addrs[i] = {r[7:0], i[3:0]};
            words[i] = 16'(randomBits(16));
            hostWriteWord(addrs[i], words[i]);
        end
        for (int i = 0; i < 8; i++) begin
            hostReadWord(addrs[i], got);
            checkValue($sformatf("word at 0x%h", addrs[i]), got, words[i]);
        end
    endtask

    // load, aluImm, store, halt with word 1 patched per op
    task automatic aluImmediateOps();
        logic [wordWidth-1:0] operand;
        logic [immWidth-1:0] imm;
        logic [wordWidth-1:0] expected;
        logic [wordWidth-1:0] got;
        hostWriteWord(12'd0, encodeMem(opLoad, dataA));
        hostWriteWord(12'd2, encodeMem(opStore, dataB));
        hostWriteWord(12'd3, encodeMem(opHalt, 12'd0));
        for (int i = 0; i < 16; i++) begin
            operand = 16'(randomBits(16));
            imm = 8'(randomBits(8));
            expected = aluModel(aluOp'(i[3:0]), operand, {8'h00, imm});
            hostWriteWord(dataA, operand);
            hostWriteWord(12'd1, encodeAlu(opAluImm, aluOp'(i[3:0]), imm));
            runProgram();
            checkValue($sformatf("accumulator for aluImm %0d", i), accumulator, expected);
            hostReadWord(dataB, got);
            checkValue($sformatf("stored word for aluImm %0d", i), got, expected);
        end
    endtask

    task automatic memOperandCase(input aluOp func, input logic [wordWidth-1:0] a,
            input logic [wordWidth-1:0] b);
        logic [wordWidth-1:0] got;
        hostWriteWord(12'd2, encodeAlu(opAlu, func, 8'h00));
        hostWriteWord(dataA, a);
        hostWriteWord(dataB, b);
        runProgram();
        hostReadWord(dataOut, got);
        checkValue($sformatf("memory result for alu %0d", func), got, aluModel(func, a, b));
        checkValue("accumulator after alu with B", accumulator, aluModel(func, a, b));
    endtask

    task automatic memoryOperands();
        logic [wordWidth-1:0] x;
        logic [wordWidth-1:0] y;
        hostWriteWord(12'd0, encodeMem(opLoad, dataA));
        hostWriteWord(12'd1, encodeMem(opLoadB, dataB));
        hostWriteWord(12'd3, encodeMem(opStore, dataOut));
        hostWriteWord(12'd4, encodeMem(opHalt, 12'd0));
        x = 16'(randomBits(16));
        y = 16'(randomBits(16));
        memOperandCase(aluAdd, x, y);
        memOperandCase(aluMul, y, x);
        // B zero saturates
        memOperandCase(aluDiv, x, 16'd0);
        memOperandCase(aluDiv, x, y | 16'd1);
        memOperandCase(aluGreater, x, y);
        memOperandCase(aluGreater, y, x);
        memOperandCase(aluEqual, x, x);
        memOperandCase(aluEqual, x, x ^ 16'd1);
    endtask

    // countdown in dataA, pass count in dataB, marker in dataOut
    task automatic controlFlow();
        logic [wordWidth-1:0] code [10];
        logic [wordWidth-1:0] count;
        logic [wordWidth-1:0] got;
        code[0] = encodeMem(opLoad, dataA);
        code[1] = encodeMem(opJumpZero, 12'd9);
        code[2] = encodeAlu(opAluImm, aluSub, 8'd1);
        code[3] = encodeMem(opStore, dataA);
        code[4] = encodeMem(opLoad, dataB);
        code[5] = encodeAlu(opAluImm, aluAdd, 8'd1);
        code[6] = encodeMem(opStore, dataB);
        code[7] = encodeMem(opJump, 12'd0);
        // only reachable by falling through the jump
        code[8] = encodeMem(opStore, dataOut);
        code[9] = encodeMem(opHalt, 12'd0);
        for (int i = 0; i < 10; i++) begin
            hostWriteWord(12'(i), code[i]);
        end
        count = 16'd3 + 16'(randomBits(2));
        hostWriteWord(dataA, count);
        hostWriteWord(dataB, 16'd0);
        hostWriteWord(dataOut, 16'h5a5a);
        runProgram();
        checkValue("accumulator after countdown", accumulator, 16'd0);
        hostReadWord(dataA, got);
        checkValue("countdown word", got, 16'd0);
        hostReadWord(dataB, got);
        checkValue("pass counter", got, count);
        hostReadWord(dataOut, got);
        checkValue("skipped marker", got, 16'h5a5a);
    endtask

    // host read raised while the countdown program runs
    task automatic backPressure();
        int cycles;
        cycles = 0;
        hostWriteWord(dataA, 16'd12);
        hostWriteWord(dataB, 16'd0);
        pulseStart();
        repeat (5) @(negedge clock);
        checkValue("halted when request raised", 16'(halted), 16'd0);
        hostWrite = 1'b0;
        hostAddr = dataB;
        hostReq = 1'b1;
        while (hostAck !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (!halted) begin
                checkValue("hostAck while running", 16'(hostAck), 16'd0);
            end
            if (cycles > waitLimit) begin
                abortRun("held host read never completed");
            end
        end
        checkValue("halted at acknowledge", 16'(halted), 16'd1);
        checkValue("held read data", hostReadData, 16'd12);
        hostReq = 1'b0;
        waitForAck(1'b0);
    endtask

    // hostAck must drop within a cycle of hostReq falling
    always @(posedge clock) begin
        if (hostReq) begin
            reqLowCycles = 0;
        end else if (reqLowCycles < 2) begin
            reqLowCycles++;
        end
        if (!rst && reqLowCycles >= 2 && hostAck) begin
            abortRun("hostAck still high two cycles after hostReq fell");
        end
    end

    initial begin
        #(testCount * 20000);
        abortRun("simulation timed out");
    end

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        hostReq = 1'b0;
        hostWrite = 1'b0;
        hostAddr = '0;
        hostWriteData = '0;
        repeat (5) @(negedge clock);
        rst = 1'b0;
        checkValue("halted after reset", 16'(halted), 16'd1);
        checkValue("hostAck after reset", 16'(hostAck), 16'd0);
        checkValue("accumulator after reset", accumulator, 16'd0);
        hostRoundTrip();
        aluImmediateOps();
        memoryOperands();
        controlFlow();
        backPressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
